//--- all.f
+incdir+.
mipsPkg.sv
alu.sv
regFile.sv
execControl.sv
retireCounter.sv
execCore.sv
execCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = execCoreTb
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@if ! grep -q "test passed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- execCoreTb.sv
`timescale 1ns/100ps

module execCoreTb import mipsPkg::*; ();

  localparam logic [2:0] kindDone    = 3'b001;
  localparam logic [2:0] kindTrap    = 3'b010;
  localparam logic [2:0] kindIllegal = 3'b100;
  localparam int numDraws = 8;
  localparam int opsPerDraw = 12;

  logic clk = 1'b0;
  logic rstN, instrValid, ready, done, trap, illegal;
  dataWordT instr, dbgData;
  regAddrT dbgAddr;
  countT retireCount, trapCount;
  countT expRetire, expTrap;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int limit = 1000;

  // Stimulus table
  string names[$];
  dataWordT words[$];
  logic [2:0] kinds[$];
  regAddrT dests[$];
  dataWordT values[$];

  execCore uut (
    .clk(clk), .rstN(rstN),
    .instrValid(instrValid), .instr(instr),
    .ready(ready), .done(done), .trap(trap), .illegal(illegal),
    .dbgAddr(dbgAddr), .dbgData(dbgData),
    .retireCount(retireCount), .trapCount(trapCount)
  );

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic dataWordT rType(input regAddrT rs, input regAddrT rt, input regAddrT rd,
                                     input shamtT sh, input logic [5:0] fn);
    return {opRType, rs, rt, rd, sh, fn};
  endfunction

  function automatic dataWordT iType(input logic [5:0] op, input regAddrT rs, input regAddrT rt,
                                     input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic checkWord(input string name, input dataWordT expVal, input dataWordT actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expVal, actVal);
    end
  endtask

  task automatic checkCount(input string name, input countT expVal, input countT actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("error %s: expected %0d, actual %0d", name, expVal, actVal);
    end
  endtask

  // Outcome as {illegal, trap, done}
  task automatic checkOutcome(input string name, input logic [2:0] expVal,
                              input logic [2:0] actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("error %s outcome: expected %b, actual %b", name, expVal, actVal);
    end
  endtask

  task automatic addEntry(input string name, input dataWordT word, input logic [2:0] kind,
                          input regAddrT dest, input dataWordT value);
    names.push_back(name);
    words.push_back(word);
    kinds.push_back(kind);
    dests.push_back(dest);
    values.push_back(value);
  endtask

  // Issue one instruction from a falling edge
  task automatic runInstr(input string name, input dataWordT word, input logic [2:0] kind,
                          input regAddrT dest, input dataWordT expVal);
    while (!ready) begin
      @(negedge clk);
    end
    instrValid = 1'b1;
    instr = word;
    @(negedge clk);
    // Strobe held while busy with an illegal word
    instr = iType(6'h3F, 5'd0, 5'd0, 16'h0000);
    for (int n = 1; n < 3; n++) begin
      if (ready || done || trap || illegal) begin
        errors++;
        $display("%s: ready or outcome seen %0d cycles after accept", name, n);
      end
      @(negedge clk);
    end
    instrValid = 1'b0;
    checkOutcome(name, kind, {illegal, trap, done});
    if (kind == kindDone) expRetire = expRetire + countT'(1);
    if (kind == kindTrap) expTrap = expTrap + countT'(1);
    dbgAddr = dest;
    @(negedge clk);
    if (!ready || done || trap || illegal) begin
      errors++;
      $display("%s: core not back to idle one cycle after the outcome pulse", name);
    end
    checkWord(name, expVal, dbgData);
    checkCount({name, " retire count"}, expRetire, retireCount);
    checkCount({name, " trap count"}, expTrap, trapCount);
  endtask

  initial begin
    logic [15:0] ra, rb;
    dataWordT a, b, word, expVal;
    void'($urandom(87));
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    dbgAddr = '0;
    expRetire = '0;
    expTrap = '0;

    // Logic and immediates
    addEntry("ori r1", iType(opOri, 5'd0, 5'd1, 16'h00F0), kindDone, 5'd1, 32'h0000_00F0);
    addEntry("ori r2", iType(opOri, 5'd0, 5'd2, 16'h0FF0), kindDone, 5'd2, 32'h0000_0FF0);
    addEntry("and", rType(5'd1, 5'd2, 5'd3, 5'd0, fnAnd), kindDone, 5'd3, 32'h0000_00F0);
    addEntry("or", rType(5'd1, 5'd2, 5'd4, 5'd0, fnOr), kindDone, 5'd4, 32'h0000_0FF0);
    addEntry("xor", rType(5'd1, 5'd2, 5'd5, 5'd0, fnXor), kindDone, 5'd5, 32'h0000_0F00);
    addEntry("nor", rType(5'd1, 5'd2, 5'd6, 5'd0, fnNor), kindDone, 5'd6, 32'hFFFF_F00F);
    addEntry("andi", iType(opAndi, 5'd6, 5'd7, 16'hFFFF), kindDone, 5'd7, 32'h0000_F00F);
    addEntry("xori", iType(opXori, 5'd1, 5'd8, 16'h8000), kindDone, 5'd8, 32'h0000_80F0);
    addEntry("ori high", iType(opOri, 5'd0, 5'd27, 16'h8001), kindDone, 5'd27, 32'h0000_8001);
    addEntry("addi -1", iType(opAddi, 5'd0, 5'd9, 16'hFFFF), kindDone, 5'd9, 32'hFFFF_FFFF);
    addEntry("addi 1", iType(opAddi, 5'd0, 5'd10, 16'h0001), kindDone, 5'd10, 32'h0000_0001);
    addEntry("addi -2", iType(opAddi, 5'd9, 5'd26, 16'hFFFE), kindDone, 5'd26, 32'hFFFF_FFFD);
    // Signed against unsigned compares
    addEntry("slt 1,-1", rType(5'd10, 5'd9, 5'd11, 5'd0, fnSlt), kindDone, 5'd11, 32'h0);
    addEntry("sltu 1,max", rType(5'd10, 5'd9, 5'd12, 5'd0, fnSltu), kindDone, 5'd12, 32'h1);
    addEntry("slt -1,1", rType(5'd9, 5'd10, 5'd13, 5'd0, fnSlt), kindDone, 5'd13, 32'h1);
    addEntry("slti", iType(opSlti, 5'd9, 5'd14, 16'h0005), kindDone, 5'd14, 32'h1);
    addEntry("sltiu", iType(opSltiu, 5'd10, 5'd15, 16'hFFFF), kindDone, 5'd15, 32'h1);
    // Shifts where the low bits of r16 give 4
    addEntry("addi r16", iType(opAddi, 5'd0, 5'd16, 16'h0024), kindDone, 5'd16, 32'h24);
    addEntry("sllv", rType(5'd16, 5'd1, 5'd17, 5'd0, fnSllv), kindDone, 5'd17, 32'h0000_0F00);
    addEntry("srlv", rType(5'd16, 5'd6, 5'd18, 5'd0, fnSrlv), kindDone, 5'd18, 32'h0FFF_FF00);
    addEntry("srav", rType(5'd16, 5'd6, 5'd19, 5'd0, fnSrav), kindDone, 5'd19, 32'hFFFF_FF00);
    addEntry("sll", rType(5'd0, 5'd1, 5'd20, 5'd8, fnSll), kindDone, 5'd20, 32'h0000_F000);
    addEntry("srl", rType(5'd0, 5'd9, 5'd21, 5'd28, fnSrl), kindDone, 5'd21, 32'h0000_000F);
    addEntry("sra", rType(5'd0, 5'd6, 5'd22, 5'd8, fnSra), kindDone, 5'd22, 32'hFFFF_FFF0);
    addEntry("srl max", rType(5'd0, 5'd9, 5'd23, 5'd1, fnSrl), kindDone, 5'd23, 32'h7FFF_FFFF);
    addEntry("sll min", rType(5'd0, 5'd10, 5'd25, 5'd31, fnSll), kindDone, 5'd25, 32'h8000_0000);
    addEntry("add", rType(5'd1, 5'd2, 5'd28, 5'd0, fnAdd), kindDone, 5'd28, 32'h0000_10E0);
    addEntry("sub", rType(5'd10, 5'd9, 5'd29, 5'd0, fnSub), kindDone, 5'd29, 32'h0000_0002);
    // Overflow traps leave the destination alone
    addEntry("add ovf", rType(5'd23, 5'd10, 5'd1, 5'd0, fnAdd), kindTrap, 5'd1, 32'h0000_00F0);
    addEntry("sub ovf", rType(5'd25, 5'd10, 5'd23, 5'd0, fnSub), kindTrap, 5'd23, 32'h7FFF_FFFF);
    addEntry("addi ovf", iType(opAddi, 5'd23, 5'd2, 16'h0001), kindTrap, 5'd2, 32'h0000_0FF0);
    addEntry("add r0", rType(5'd1, 5'd2, 5'd0, 5'd0, fnAdd), kindDone, 5'd0, 32'h0);
    addEntry("bad opcode", iType(6'h3F, 5'd1, 5'd3, 16'h1234), kindIllegal, 5'd3, 32'hF0);
    addEntry("bad funct", rType(5'd1, 5'd2, 5'd4, 5'd0, 6'h01), kindIllegal, 5'd4, 32'hFF0);
    addEntry("load opcode", iType(6'h23, 5'd1, 5'd5, 16'h0000), kindIllegal, 5'd5, 32'hF00);
    limit = (words.size() + numDraws * opsPerDraw) * 8 + 2 * 32 + 100;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    ////////////////////////////////////////////////////////////
    // Reset state
    ////////////////////////////////////////////////////////////
    for (int i = 0; i < 32; i++) begin
      dbgAddr = 5'(i);
      @(negedge clk);
      if (!ready || done || trap || illegal) begin
        errors++;
        $display("after reset: ready low or an outcome pulse seen");
      end
      checkWord($sformatf("reset r%0d", i), '0, dbgData);
    end
    checkCount("reset retire count", '0, retireCount);
    checkCount("reset trap count", '0, trapCount);

    for (int i = 0; i < words.size(); i++) begin
      runInstr(names[i], words[i], kinds[i], dests[i], values[i]);
    end

    // Random operands with a sign extended and b zero extended
    for (int d = 0; d < numDraws; d++) begin
      ra = 16'($urandom());
      rb = 16'($urandom());
      a = {{16{ra[15]}}, ra};
      b = {16'h0000, rb};
      runInstr("load a", iType(opAddi, 5'd0, 5'd1, ra), kindDone, 5'd1, a);
      runInstr("load b", iType(opOri, 5'd0, 5'd2, rb), kindDone, 5'd2, b);
      for (int op = 0; op < 10; op++) begin
        case (op)
          0: begin
            word = rType(5'd1, 5'd2, 5'd3, 5'd0, fnAdd);
            expVal = a + b;
          end
          1: begin
            word = rType(5'd1, 5'd2, 5'd3, 5'd0, fnSub);
            expVal = a - b;
          end
          2: begin
            word = rType(5'd1, 5'd2, 5'd3, 5'd0, fnSlt);
            expVal = {31'b0, $signed(a) < $signed(b)};
          end
          3: begin
            word = rType(5'd1, 5'd2, 5'd3, 5'd0, fnSltu);
            expVal = {31'b0, a < b};
          end
          4: begin
            word = rType(5'd2, 5'd1, 5'd3, 5'd0, fnSllv);
            expVal = a << rb[4:0];
          end
          5: begin
            word = rType(5'd2, 5'd1, 5'd3, 5'd0, fnSrlv);
            expVal = a >> rb[4:0];
          end
          6: begin
            word = rType(5'd2, 5'd1, 5'd3, 5'd0, fnSrav);
            expVal = $signed(a) >>> rb[4:0];
          end
          7: begin
            word = rType(5'd0, 5'd1, 5'd3, rb[4:0], fnSll);
            expVal = a << rb[4:0];
          end
          8: begin
            word = rType(5'd0, 5'd1, 5'd3, rb[4:0], fnSrl);
            expVal = a >> rb[4:0];
          end
          default: begin
            word = rType(5'd0, 5'd1, 5'd3, rb[4:0], fnSra);
            expVal = $signed(a) >>> rb[4:0];
          end
        endcase
        runInstr($sformatf("random %0d op %0d", d, op), word, kindDone, 5'd3, expVal);
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- execCore.sv
`timescale 1ns/100ps

module execCore import mipsPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     instrValid,
  input  dataWordT instr,
  output logic     ready,
  output logic     done,
  output logic     trap,
  output logic     illegal,
  input  regAddrT  dbgAddr,
  output dataWordT dbgData,
  output countT    retireCount,
  output countT    trapCount
);

  regAddrT rsAddr, rtAddr, wrAddr;
  dataWordT rsData, rtData, wrData;
  dataWordT srcA, srcB, aluResult;
  shamtT shamt;
  aluOpT aluControl;
  logic aluOutSel, overflow, wrEn;
  logic retirePulse, trapPulse;

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////
  execControl ctrl (
    .clk(clk), .rstN(rstN),
    .instrValid(instrValid), .instr(instr),
    .rsData(rsData), .rtData(rtData),
    .aluResult(aluResult), .overflow(overflow),
    .ready(ready),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr),
    .wrEn(wrEn), .wrData(wrData),
    .srcA(srcA), .srcB(srcB), .shamt(shamt),
    .aluControl(aluControl), .aluOutSel(aluOutSel),
    .done(done), .trap(trap), .illegal(illegal),
    .retirePulse(retirePulse), .trapPulse(trapPulse)
  );

  regFile regs (
    .clk(clk), .rstN(rstN),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr), .dbgAddr(dbgAddr),
    .wrEn(wrEn), .wrData(wrData),
    .rsData(rsData), .rtData(rtData), .dbgData(dbgData)
  );

  alu alu0 (
    .srcA(srcA), .srcB(srcB), .shamt(shamt),
    .aluControl(aluControl), .aluOutSel(aluOutSel),
    .aluResult(aluResult), .overflow(overflow)
  );

  // Event counts
  retireCounter counters (
    .clk(clk), .rstN(rstN),
    .retirePulse(retirePulse), .trapPulse(trapPulse),
    .retireCount(retireCount), .trapCount(trapCount)
  );

endmodule

//--- retireCounter.sv
`timescale 1ns/100ps

module retireCounter import mipsPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  retirePulse,
  input  logic  trapPulse,
  output countT retireCount,
  output countT trapCount
);

  // Completed instructions
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      retireCount <= '0;
    end else if (retirePulse) begin
      retireCount <= retireCount + countT'(1);
    end
  end

  // Overflow traps
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      trapCount <= '0;
    end else if (trapPulse) begin
      trapCount <= trapCount + countT'(1);
    end
  end

endmodule

//--- execControl.sv
`timescale 1ns/100ps

module execControl import mipsPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     instrValid,
  input  dataWordT instr,
  input  dataWordT rsData,
  input  dataWordT rtData,
  input  dataWordT aluResult,
  input  logic     overflow,
  output logic     ready,
  output regAddrT  rsAddr,
  output regAddrT  rtAddr,
  output regAddrT  wrAddr,
  output logic     wrEn,
  output dataWordT wrData,
  output dataWordT srcA,
  output dataWordT srcB,
  output shamtT    shamt,
  output aluOpT    aluControl,
  output logic     aluOutSel,
  output logic     done,
  output logic     trap,
  output logic     illegal,
  output logic     retirePulse,
  output logic     trapPulse
);

  execStateT state;
  dataWordT instrQ, rsQ, rtQ, immQ, resultQ;
  logic legalQ, ovfQ, useImmQ;
  regAddrT destQ;

  // Decoder outputs
  aluOpT decOp;
  logic decOutSel, decUseImm, decSignExt, decLegal, decUseRt;
  logic [5:0] opcode, funct;
  logic [15:0] imm16;

  assign opcode = instrQ[31:26];
  assign funct  = instrQ[5:0];
  assign imm16  = instrQ[15:0];
  assign rsAddr = instrQ[25:21];
  assign rtAddr = instrQ[20:16];

  ////////////////////////////////////////////////////////////
  // Instruction decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    decOp = aluAdd;
    decOutSel = 1'b0;
    decUseImm = 1'b0;
    decSignExt = 1'b0;
    decUseRt = 1'b0;
    decLegal = 1'b1;
    case (opcode)
      opRType: begin
        case (funct)
          fnSll:  begin decOp = aluSllv; decOutSel = 1'b1; end
          fnSrl:  begin decOp = aluSrlv; decOutSel = 1'b1; end
          fnSra:  begin decOp = aluSrav; decOutSel = 1'b1; end
          fnSllv: decOp = aluSllv;
          fnSrlv: decOp = aluSrlv;
          fnSrav: decOp = aluSrav;
          fnAdd:  decOp = aluAdd;
          fnSub:  decOp = aluSub;
          fnAnd:  decOp = aluAnd;
          fnOr:   decOp = aluOr;
          fnXor:  decOp = aluXor;
          fnNor:  decOp = aluNor;
          fnSlt:  decOp = aluSlt;
          fnSltu: decOp = aluSltu;
          default: decLegal = 1'b0;
        endcase
      end
      opAddi:  begin decOp = aluAdd;  decSignExt = 1'b1; end
      opSlti:  begin decOp = aluSlt;  decSignExt = 1'b1; end
      opSltiu: begin decOp = aluSltu; decSignExt = 1'b1; end
      opAndi:  decOp = aluAnd;
      opOri:   decOp = aluOr;
      opXori:  decOp = aluXor;
      default: decLegal = 1'b0;
    endcase
    // Every I-type takes the immediate and writes rt
    if (opcode != opRType) begin
      decUseImm = 1'b1;
      decUseRt = 1'b1;
    end
  end

  // State and outcome flags
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state  <= stIdle;
      legalQ <= 1'b0;
      ovfQ   <= 1'b0;
    end else begin
      case (state)
        stIdle:      if (instrValid) state <= stDecode;
        stDecode: begin
          legalQ <= decLegal;
          state  <= stExecute;
        end
        stExecute: begin
          ovfQ  <= overflow;
          state <= stWriteback;
        end
        default:     state <= stIdle;
      endcase
    end
  end

  // Operands, decode results and ALU result
  always_ff @(posedge clk) begin
    if (state == stIdle && instrValid) instrQ <= instr;
    if (state == stDecode) begin
      rsQ <= rsData;
      rtQ <= rtData;
      immQ <= decSignExt ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
      useImmQ <= decUseImm;
      destQ <= decUseRt ? instrQ[20:16] : instrQ[15:11];
      aluControl <= decOp;
      aluOutSel <= decOutSel;
    end
    if (state == stExecute) resultQ <= aluResult;
  end

  assign srcA  = rsQ;
  assign srcB  = useImmQ ? immQ : rtQ;
  assign shamt = instrQ[10:6];

  ////////////////////////////////////////////////////////////
  // Writeback and outcome pulses
  ////////////////////////////////////////////////////////////
  assign ready   = (state == stIdle);
  assign done    = (state == stWriteback) && legalQ && !ovfQ;
  assign trap    = (state == stWriteback) && legalQ && ovfQ;
  assign illegal = (state == stWriteback) && !legalQ;
  assign wrEn    = done;
  assign wrAddr  = destQ;
  assign wrData  = resultQ;
  assign retirePulse = done;
  assign trapPulse   = trap;

endmodule

//--- regFile.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module regFile import mipsPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  regAddrT  rsAddr,
  input  regAddrT  rtAddr,
  input  regAddrT  wrAddr,
  input  regAddrT  dbgAddr,
  input  logic     wrEn,
  input  dataWordT wrData,
  output dataWordT rsData,
  output dataWordT rtData,
  output dataWordT dbgData
);

  dataWordT regs [`MIPS_NUM_REGS];

  // Register 0 is never written
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  ////////////////////////////////////////////////////////////
  // Asynchronous read ports
  ////////////////////////////////////////////////////////////
  assign rsData  = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData  = (rtAddr == '0) ? '0 : regs[rtAddr];
  assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

//--- alu.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module alu import mipsPkg::*; (
  input  dataWordT srcA,
  input  dataWordT srcB,
  input  shamtT    shamt,
  input  aluOpT    aluControl,
  input  logic     aluOutSel,
  output dataWordT aluResult,
  output logic     overflow
);

  // One extra bit to catch signed overflow
  logic [`MIPS_XLEN:0] wideSum;
  logic [`MIPS_XLEN:0] wideDiff;
  shamtT shiftAmt;

  assign wideSum  = {srcA[`MIPS_XLEN-1], srcA} + {srcB[`MIPS_XLEN-1], srcB};
  assign wideDiff = {srcA[`MIPS_XLEN-1], srcA} - {srcB[`MIPS_XLEN-1], srcB};

  // Fixed shifts take shamt, variable shifts take rs
  assign shiftAmt = aluOutSel ? shamt : srcA[`MIPS_SHAMT_W-1:0];

  always_comb begin
    aluResult = '0;
    overflow  = 1'b0;
    case (aluControl)
      aluAdd: begin
        aluResult = wideSum[`MIPS_XLEN-1:0];
        overflow  = wideSum[`MIPS_XLEN] != wideSum[`MIPS_XLEN-1];
      end
      aluSub: begin
        aluResult = wideDiff[`MIPS_XLEN-1:0];
        overflow  = wideDiff[`MIPS_XLEN] != wideDiff[`MIPS_XLEN-1];
      end
      aluOr:  aluResult = srcA | srcB;
      aluAnd: aluResult = srcA & srcB;
      aluXor: aluResult = srcA ^ srcB;
      aluNor: aluResult = ~(srcA | srcB);
      aluSlt: begin
        aluResult = ($signed(srcA) < $signed(srcB)) ? dataWordT'(1) : '0;
      end
      aluSltu: begin
        aluResult = (srcA < srcB) ? dataWordT'(1) : '0;
      end
      aluSllv: aluResult = srcB << shiftAmt;
      aluSrlv: aluResult = srcB >> shiftAmt;
      aluSrav: aluResult = $signed(srcB) >>> shiftAmt;
      default: begin
        aluResult = '0;
        overflow  = 1'b0;
      end
    endcase
  end

endmodule

//--- mipsPkg.sv
`include "mips_macros.svh"

package mipsPkg;

  typedef logic [`MIPS_XLEN-1:0] dataWordT;
  typedef logic [`MIPS_REG_ADDR_W-1:0] regAddrT;
  typedef logic [`MIPS_SHAMT_W-1:0] shamtT;
  typedef logic [`MIPS_COUNT_W-1:0] countT;

  // ALU operation codes
  typedef enum logic [`MIPS_ALU_OP_W-1:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluOr   = 4'd2,
    aluAnd  = 4'd3,
    aluXor  = 4'd4,
    aluNor  = 4'd5,
    aluSlt  = 4'd6,
    aluSltu = 4'd7,
    aluSllv = 4'd8,
    aluSrlv = 4'd9,
    aluSrav = 4'd10
  } aluOpT;

  typedef enum logic [1:0] {
    stIdle,
    stDecode,
    stExecute,
    stWriteback
  } execStateT;

  // Opcodes
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opAddi  = 6'h08;
  localparam logic [5:0] opSlti  = 6'h0A;
  localparam logic [5:0] opSltiu = 6'h0B;
  localparam logic [5:0] opAndi  = 6'h0C;
  localparam logic [5:0] opOri   = 6'h0D;
  localparam logic [5:0] opXori  = 6'h0E;

  // R-type funct codes
  localparam logic [5:0] fnSll  = 6'h00;
  localparam logic [5:0] fnSrl  = 6'h02;
  localparam logic [5:0] fnSra  = 6'h03;
  localparam logic [5:0] fnSllv = 6'h04;
  localparam logic [5:0] fnSrlv = 6'h06;
  localparam logic [5:0] fnSrav = 6'h07;
  localparam logic [5:0] fnAdd  = 6'h20;
  localparam logic [5:0] fnSub  = 6'h22;
  localparam logic [5:0] fnAnd  = 6'h24;
  localparam logic [5:0] fnOr   = 6'h25;
  localparam logic [5:0] fnXor  = 6'h26;
  localparam logic [5:0] fnNor  = 6'h27;
  localparam logic [5:0] fnSlt  = 6'h2A;
  localparam logic [5:0] fnSltu = 6'h2B;

endpackage

//--- mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath width
`define MIPS_XLEN 32

// Register file geometry
`define MIPS_REG_ADDR_W 5
`define MIPS_NUM_REGS 32

// Shift amount field
`define MIPS_SHAMT_W 5

// ALU operation code width
`define MIPS_ALU_OP_W 4

// Retire and trap counters
`define MIPS_COUNT_W 16

`endif
